//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_alu_top -f mips_alu.f -o sim_alu
	./obj_dir/sim_alu | tee sim.log
	grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

//--- hw/alu_master.sv
`timescale 1ns/1ps

module alu_master (
    input  logic                            clk,
    input  logic                            reset,
    input  alu_pkg::alu_req_t               req,
    input  logic [2*alu_pkg::data_w-1:0]    hilo,
    input  logic [alu_pkg::data_w-1:0]      cp0_data,
    input  logic [2*alu_pkg::data_w-1:0]    product,
    input  logic                            mul_ready,
    input  logic [2*alu_pkg::data_w-1:0]    quotient_rem,
    input  logic                            div_ready,
    output logic                            mul_start,
    output logic                            mul_signed,
    output logic                            div_start,
    output logic                            div_signed,
    output logic                            stall,
    output logic                            overflow,
    output logic [alu_pkg::data_w-1:0]      y,
    output alu_pkg::spr_wr_t                spr_wr
);

    // b doubled so a right shift of the pair is a rotate
    logic [2*alu_pkg::data_w-1:0] rot_pair;

    assign rot_pair = {req.b, req.b} >> req.a[4:0];

    // leading bits of v equal to ones, 0 to 32
    function automatic logic [alu_pkg::data_w-1:0] lead_count(
        input logic [alu_pkg::data_w-1:0] v,
        input logic                       ones
    );
        logic [alu_pkg::data_w-1:0] n;
        logic                       hit;
        n = '0;
        hit = 1'b0;
        for (int i = alu_pkg::data_w - 1; i >= 0; i--) begin
            if (v[i] != ones) begin
                hit = 1'b1;
            end
            if (!hit) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    always_comb begin
        y = '0;
        overflow = 1'b0;
        stall = 1'b0;
        mul_start = 1'b0;
        mul_signed = 1'b0;
        div_start = 1'b0;
        div_signed = 1'b0;
        spr_wr = '0;
        case (req.op)
            alu_pkg::ADD: begin
                y = req.a + req.b;
                overflow = (req.a[31] == req.b[31]) && (y[31] != req.a[31]);
            end
            alu_pkg::ADDU: y = req.a + req.b;
            alu_pkg::SUB: begin
                y = req.a - req.b;
                // operands of different sign and the result flips away from a
                overflow = (req.a[31] != req.b[31]) && (y[31] != req.a[31]);
            end
            alu_pkg::SUBU: y = req.a - req.b;
            alu_pkg::SLT: y = {31'd0, $signed(req.a) < $signed(req.b)};
            alu_pkg::SLTU: y = {31'd0, req.a < req.b};
            alu_pkg::AND: y = req.a & req.b;
            alu_pkg::OR: y = req.a | req.b;
            alu_pkg::NOR: y = ~(req.a | req.b);
            alu_pkg::XOR: y = req.a ^ req.b;
            alu_pkg::LUI: y = {req.b[15:0], 16'd0};
            // shift amount always comes in a[4:0]
            alu_pkg::SLL: y = req.b << req.a[4:0];
            alu_pkg::SRL: y = req.b >> req.a[4:0];
            alu_pkg::SRA: y = $signed(req.b) >>> req.a[4:0];
            alu_pkg::ROTR: y = rot_pair[alu_pkg::data_w-1:0];
            alu_pkg::CLO: y = lead_count(req.a, 1'b1);
            alu_pkg::CLZ: y = lead_count(req.a, 1'b0);
            // data moves
            alu_pkg::MTHI: begin
                spr_wr.hilo_we = 1'b1;
                spr_wr.hilo = {req.a, hilo[31:0]};
            end
            alu_pkg::MTLO: begin
                spr_wr.hilo_we = 1'b1;
                spr_wr.hilo = {hilo[63:32], req.a};
            end
            alu_pkg::MFHI: y = hilo[63:32];
            alu_pkg::MFLO: y = hilo[31:0];
            alu_pkg::MFC0: y = cp0_data;
            alu_pkg::MTC0: begin
                spr_wr.cp0_we = 1'b1;
                spr_wr.cp0_sel = req.cp0_sel;
                spr_wr.cp0_data = req.a;
            end
            alu_pkg::MOV: y = req.a;
            // multiply class, held until the unit pulses ready
            alu_pkg::MULT, alu_pkg::MULTU, alu_pkg::MADD, alu_pkg::MADDU,
            alu_pkg::MSUB, alu_pkg::MSUBU: begin
                mul_signed = (req.op == alu_pkg::MULT) || (req.op == alu_pkg::MADD) ||
                             (req.op == alu_pkg::MSUB);
                mul_start = !mul_ready;
                stall = !mul_ready;
                if (mul_ready) begin
                    spr_wr.hilo_we = 1'b1;
                    case (req.op)
                        alu_pkg::MADD, alu_pkg::MADDU: spr_wr.hilo = hilo + product;
                        alu_pkg::MSUB, alu_pkg::MSUBU: spr_wr.hilo = hilo - product;
                        default: begin
                            spr_wr.hilo = product;
                            y = product[31:0];
                        end
                    endcase
                end
            end
            // divide, remainder lands in HI and quotient in LO
            alu_pkg::DIV, alu_pkg::DIVU: begin
                div_signed = (req.op == alu_pkg::DIV);
                div_start = !div_ready;
                stall = !div_ready;
                if (div_ready) begin
                    spr_wr.hilo_we = 1'b1;
                    spr_wr.hilo = quotient_rem;
                end
            end
            default: y = '0;
        endcase
    end

endmodule

//--- hw/alu_pkg.sv
package alu_pkg;

    // operand and result width
    localparam int data_w = 32;

    // coprocessor-0 scratch file
    localparam int cp0_regs = 8;
    localparam int cp0_sel_w = 3;

    // 33 opcodes do not fit in five bits, so the field is six wide
    localparam int op_w = 6;

    typedef enum logic [op_w-1:0] {
        NOP = 6'd0,
        ADD,
        ADDU,
        SUB,
        SUBU,
        SLT,
        SLTU,
        AND,
        OR,
        NOR,
        XOR,
        LUI,
        SLL,
        SRL,
        SRA,
        ROTR,
        CLO,
        CLZ,
        MTHI,
        MTLO,
        MFHI,
        MFLO,
        MFC0,
        MTC0,
        MOV,
        MULT,
        MULTU,
        MADD,
        MADDU,
        MSUB,
        MSUBU,
        DIV,
        DIVU
    } alu_op_e;

    // instruction presented to the execute stage each cycle
    typedef struct packed {
        alu_op_e              op;
        logic [data_w-1:0]    a;
        logic [data_w-1:0]    b;
        logic [cp0_sel_w-1:0] cp0_sel;
    } alu_req_t;

    // write-back into HI/LO and the scratch file
    typedef struct packed {
        logic                 hilo_we;
        logic [2*data_w-1:0]  hilo;
        logic                 cp0_we;
        logic [cp0_sel_w-1:0] cp0_sel;
        logic [data_w-1:0]    cp0_data;
    } spr_wr_t;

endpackage

//--- hw/alu_top.sv
`timescale 1ns/1ps

module alu_top (
    input  logic                         clk,
    input  logic                         reset,
    input  alu_pkg::alu_req_t            req,
    output logic                         stall,
    output logic                         overflow,
    output logic [alu_pkg::data_w-1:0]   y,
    output logic [2*alu_pkg::data_w-1:0] hilo
);

    logic                         mul_start;
    logic                         mul_signed;
    logic                         mul_ready;
    logic [2*alu_pkg::data_w-1:0] product;
    logic                         div_start;
    logic                         div_signed;
    logic                         div_ready;
    logic [2*alu_pkg::data_w-1:0] quotient_rem;
    logic [alu_pkg::data_w-1:0]   cp0_data;
    alu_pkg::spr_wr_t             spr_wr;

    alu_master u_master (
        .clk          (clk),
        .reset        (reset),
        .req          (req),
        .hilo         (hilo),
        .cp0_data     (cp0_data),
        .product      (product),
        .mul_ready    (mul_ready),
        .quotient_rem (quotient_rem),
        .div_ready    (div_ready),
        .mul_start    (mul_start),
        .mul_signed   (mul_signed),
        .div_start    (div_start),
        .div_signed   (div_signed),
        .stall        (stall),
        .overflow     (overflow),
        .y            (y),
        .spr_wr       (spr_wr)
    );

    // both units see the request operands directly
    mul_unit u_mul (
        .clk     (clk),
        .reset   (reset),
        .start   (mul_start),
        .sign    (mul_signed),
        .a       (req.a),
        .b       (req.b),
        .product (product),
        .ready   (mul_ready)
    );

    div_unit u_div (
        .clk          (clk),
        .reset        (reset),
        .start        (div_start),
        .sign         (div_signed),
        .a            (req.a),
        .b            (req.b),
        .quotient_rem (quotient_rem),
        .ready        (div_ready)
    );

    special_regs u_spr (
        .clk      (clk),
        .reset    (reset),
        .spr_wr   (spr_wr),
        .cp0_sel  (req.cp0_sel),
        .hilo     (hilo),
        .cp0_data (cp0_data)
    );

endmodule

//--- hw/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         sign,
    input  logic [alu_pkg::data_w-1:0]   a,
    input  logic [alu_pkg::data_w-1:0]   b,
    output logic [2*alu_pkg::data_w-1:0] quotient_rem,
    output logic                         ready
);

    logic                         busy;
    logic [5:0]                   cnt;
    logic [alu_pkg::data_w-1:0]   a_q;
    logic [alu_pkg::data_w-1:0]   b_q;
    logic                         sign_q;
    logic                         div_zero;
    logic [alu_pkg::data_w-1:0]   dvs;
    // partial remainder on top, dividend shifting out and quotient shifting in below
    logic [2*alu_pkg::data_w-1:0] work;
    logic [alu_pkg::data_w:0]     diff;
    logic [alu_pkg::data_w-1:0]   rem;
    logic [alu_pkg::data_w-1:0]   quot;
    logic                         neg_q;
    logic                         neg_r;

    // trial subtract of the divisor from remainder plus next dividend bit
    assign diff = work[63:31] - {1'b0, dvs};

    assign rem = work[63:32];
    assign quot = work[31:0];
    // a zero divisor keeps the all-ones quotient
    assign neg_q = sign_q && (a_q[31] ^ b_q[31]) && !div_zero;
    // remainder follows the dividend
    assign neg_r = sign_q && a_q[31];

    // cnt 0 takes magnitudes, 1..32 are quotient bits, 33 is sign correction
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cnt <= '0;
            ready <= 1'b0;
        end else begin
            ready <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    cnt <= '0;
                end
            end else if (cnt == 6'd33) begin
                busy <= 1'b0;
                ready <= 1'b1;
            end else begin
                cnt <= cnt + 6'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            a_q <= a;
            b_q <= b;
            sign_q <= sign;
            div_zero <= (b == '0);
        end else if (busy && cnt == 6'd0) begin
            // negate one cycle after capture, off the operand input path
            work <= {32'd0, (sign_q && a_q[31]) ? -a_q : a_q};
            dvs <= (sign_q && b_q[31]) ? -b_q : b_q;
        end else if (busy && cnt != 6'd33) begin
            // divisor of zero always fits, so q ends all ones and rem ends |a|
            if (!diff[32]) begin
                work <= {diff[31:0], work[30:0], 1'b1};
            end else begin
                work <= {work[62:0], 1'b0};
            end
        end else if (busy) begin
            quotient_rem <= {neg_r ? -rem : rem, neg_q ? -quot : quot};
        end
    end

endmodule

//--- hw/mul_unit.sv
`timescale 1ns/1ps

module mul_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         sign,
    input  logic [alu_pkg::data_w-1:0]   a,
    input  logic [alu_pkg::data_w-1:0]   b,
    output logic [2*alu_pkg::data_w-1:0] product,
    output logic                         ready
);

    logic                         busy;
    logic [5:0]                   cnt;
    logic [2*alu_pkg::data_w-1:0] mcand;
    logic [2*alu_pkg::data_w-1:0] acc;
    logic [alu_pkg::data_w-1:0]   mplier;
    logic                         neg;
    logic [alu_pkg::data_w-1:0]   mag_a;
    logic [alu_pkg::data_w-1:0]   mag_b;

    // operand magnitudes, -2^31 comes out as 2^31 unsigned
    assign mag_a = (sign && a[31]) ? -a : a;
    assign mag_b = (sign && b[31]) ? -b : b;

    // cnt 0..31 are the add steps, 32 is the final negate
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cnt <= '0;
            ready <= 1'b0;
        end else begin
            ready <= 1'b0;
            if (!busy) begin
                if (start) begin
                    busy <= 1'b1;
                    cnt <= '0;
                end
            end else if (cnt == 6'd32) begin
                busy <= 1'b0;
                ready <= 1'b1;
            end else begin
                cnt <= cnt + 6'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && start) begin
            mcand <= {32'd0, mag_a};
            mplier <= mag_b;
            acc <= '0;
            neg <= sign && (a[31] ^ b[31]);
        end else if (busy && cnt != 6'd32) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
        end else if (busy) begin
            product <= neg ? -acc : acc;
        end
    end

endmodule

//--- hw/special_regs.sv
`timescale 1ns/1ps

module special_regs (
    input  logic                            clk,
    input  logic                            reset,
    input  alu_pkg::spr_wr_t                spr_wr,
    input  logic [alu_pkg::cp0_sel_w-1:0]   cp0_sel,
    output logic [2*alu_pkg::data_w-1:0]    hilo,
    output logic [alu_pkg::data_w-1:0]      cp0_data
);

    logic [2*alu_pkg::data_w-1:0] hilo_q;
    logic [alu_pkg::data_w-1:0]   cp0_q [alu_pkg::cp0_regs];

    // HI in the upper word, LO in the lower
    always_ff @(posedge clk) begin
        if (reset) begin
            hilo_q <= '0;
        end else if (spr_wr.hilo_we) begin
            hilo_q <= spr_wr.hilo;
        end
    end

    // scratch file, one entry per write strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < alu_pkg::cp0_regs; i++) begin
                cp0_q[i] <= '0;
            end
        end else if (spr_wr.cp0_we) begin
            cp0_q[spr_wr.cp0_sel] <= spr_wr.cp0_data;
        end
    end

    assign hilo = hilo_q;

    // read port follows the request index, no bypass of a same-cycle write
    assign cp0_data = cp0_q[cp0_sel];

endmodule

//--- mips_alu.f
hw/alu_pkg.sv
hw/mul_unit.sv
hw/div_unit.sv
hw/special_regs.sv
hw/alu_master.sv
hw/alu_top.sv
tb/tb_alu_top.sv

//--- tb/tb_alu_top.sv
`timescale 1ns/1ps

module tb_alu_top;

    logic              clk;
    logic              reset;
    alu_pkg::alu_req_t req;
    logic              stall;
    logic              overflow;
    logic [31:0]       y;
    logic [63:0]       hilo;

    integer      seed;
    int          errors;
    int          checks;
    logic [31:0] ra;
    logic [31:0] rb;
    // expected HI/LO and scratch file contents
    logic [63:0] hilo_m;
    logic [31:0] cp0_m [8];

    alu_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .req      (req),
        .stall    (stall),
        .overflow (overflow),
        .y        (y),
        .hilo     (hilo)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] exp_v,
                               input logic [63:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            errors++;
            $display("Fail %s expected %h got %h", name, exp_v, act_v);
        end
    endtask

    task automatic drive_req(input alu_pkg::alu_op_e op, input logic [31:0] a,
                             input logic [31:0] b, input logic [2:0] sel);
        @(posedge clk);
        #1;
        req.op = op;
        req.a = a;
        req.b = b;
        req.cp0_sel = sel;
    endtask

    function automatic logic [31:0] lead_run(input logic [31:0] v, input logic bit_val);
        int n;
        n = 0;
        while (n < 32 && v[31 - n] == bit_val) begin
            n++;
        end
        return n;
    endfunction

    // one bit position per step
    function automatic logic [31:0] rotate_right(input logic [31:0] v, input logic [4:0] sh);
        logic [31:0] r;
        r = v;
        for (int i = 0; i < sh; i++) begin
            r = {r[0], r[31:1]};
        end
        return r;
    endfunction

    task automatic model_single(input alu_pkg::alu_op_e op, input logic [31:0] a,
                                input logic [31:0] b, input logic [2:0] sel,
                                output logic [31:0] ey, output logic eov,
                                output logic y_known);
        logic [32:0] wide;
        wide = '0;
        ey = '0;
        eov = 1'b0;
        y_known = 1'b1;
        case (op)
            alu_pkg::ADD, alu_pkg::ADDU: begin
                // sign-extended sum, top two bits disagree on overflow
                wide = {a[31], a} + {b[31], b};
                ey = wide[31:0];
                eov = (op == alu_pkg::ADD) && (wide[32] != wide[31]);
            end
            alu_pkg::SUB, alu_pkg::SUBU: begin
                wide = {a[31], a} - {b[31], b};
                ey = wide[31:0];
                eov = (op == alu_pkg::SUB) && (wide[32] != wide[31]);
            end
            // flipped sign bit turns signed order into unsigned order
            alu_pkg::SLT: ey = ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
            alu_pkg::SLTU: begin
                // borrow out of the zero-extended difference
                wide = {1'b0, a} - {1'b0, b};
                ey = {31'd0, wide[32]};
            end
            alu_pkg::AND: ey = a & b;
            alu_pkg::OR: ey = a | b;
            alu_pkg::NOR: ey = ~(a | b);
            alu_pkg::XOR: ey = a ^ b;
            alu_pkg::LUI: ey = b << 16;
            alu_pkg::SLL: ey = b << a[4:0];
            alu_pkg::SRL: ey = b >> a[4:0];
            // negative values shift in ones
            alu_pkg::SRA: ey = b[31] ? ~(~b >> a[4:0]) : (b >> a[4:0]);
            alu_pkg::ROTR: ey = rotate_right(b, a[4:0]);
            alu_pkg::CLO: ey = lead_run(a, 1'b1);
            alu_pkg::CLZ: ey = lead_run(a, 1'b0);
            alu_pkg::MFHI: ey = hilo_m[63:32];
            alu_pkg::MFLO: ey = hilo_m[31:0];
            alu_pkg::MFC0: ey = cp0_m[sel];
            alu_pkg::MOV: ey = a;
            default: y_known = 1'b0;
        endcase
    endtask

    task automatic run_single(input alu_pkg::alu_op_e op, input logic [31:0] a,
                              input logic [31:0] b, input logic [2:0] sel);
        logic [31:0] ey;
        logic        eov;
        logic        y_known;
        model_single(op, a, b, sel, ey, eov, y_known);
        drive_req(op, a, b, sel);
        #49;
        check_value("stall", 64'd0, stall);
        check_value("overflow", eov, overflow);
        if (y_known) begin
            check_value("y", ey, y);
        end
        check_value("hilo", hilo_m, hilo);
        // writes land on the coming edge
        case (op)
            alu_pkg::MTHI: hilo_m[63:32] = a;
            alu_pkg::MTLO: hilo_m[31:0] = a;
            alu_pkg::MTC0: cp0_m[sel] = a;
            default: ;
        endcase
    endtask

    task automatic run_long(input alu_pkg::alu_op_e op, input logic [31:0] a,
                            input logic [31:0] b);
        logic [63:0] prod;
        logic [63:0] exp_hilo;
        longint      sa;
        longint      sb;
        longint      q;
        longint      r;
        int          cycles;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        if (op == alu_pkg::MULT || op == alu_pkg::MADD || op == alu_pkg::MSUB) begin
            prod = sa * sb;
        end else begin
            prod = {32'd0, a} * {32'd0, b};
        end
        case (op)
            alu_pkg::MULT, alu_pkg::MULTU: exp_hilo = prod;
            alu_pkg::MADD, alu_pkg::MADDU: exp_hilo = hilo_m + prod;
            alu_pkg::MSUB, alu_pkg::MSUBU: exp_hilo = hilo_m - prod;
            alu_pkg::DIV: begin
                if (b == 32'd0) begin
                    exp_hilo = {a, 32'hffff_ffff};
                end else begin
                    // truncates toward zero, remainder keeps the dividend sign
                    q = sa / sb;
                    r = sa % sb;
                    exp_hilo = {r[31:0], q[31:0]};
                end
            end
            default: begin
                if (b == 32'd0) begin
                    exp_hilo = {a, 32'hffff_ffff};
                end else begin
                    exp_hilo = {a % b, a / b};
                end
            end
        endcase
        drive_req(op, a, b, 3'd0);
        #49;
        check_value("stall", 64'd1, stall);
        check_value("hilo", hilo_m, hilo);
        cycles = 0;
        while (stall === 1'b1 && cycles < 100) begin
            @(posedge clk);
            #50;
            cycles++;
        end
        if (stall !== 1'b0) begin
            errors++;
            $display("%s stall never ended within 100 cycles", op.name());
        end else if (op == alu_pkg::MULT || op == alu_pkg::MULTU) begin
            check_value("y", exp_hilo[31:0], y);
        end
        hilo_m = exp_hilo;
    endtask

    initial begin
        seed = 32'ha499;
        errors = 0;
        checks = 0;
        hilo_m = '0;
        for (int s = 0; s < 8; s++) begin
            cp0_m[s] = '0;
        end
        req = '0;
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        // state after reset
        for (int s = 0; s < 8; s++) begin
            run_single(alu_pkg::MFC0, 32'd0, 32'd0, 3'(s));
        end

        // every single-cycle op on random operands
        for (int k = int'(alu_pkg::ADD); k <= int'(alu_pkg::MOV); k++) begin
            repeat (4) begin
                ra = $random(seed);
                rb = $random(seed);
                run_single(alu_pkg::alu_op_e'(k), ra, rb, rb[2:0]);
            end
        end

        // signed overflow edges
        run_single(alu_pkg::ADD, 32'h7fff_ffff, 32'd1, 3'd0);
        run_single(alu_pkg::ADD, 32'h8000_0000, 32'h8000_0000, 3'd0);
        run_single(alu_pkg::SUB, 32'h8000_0000, 32'd1, 3'd0);
        run_single(alu_pkg::SUB, 32'h7fff_ffff, 32'hffff_ffff, 3'd0);

        // shift by 0 and 31, a zero amount with upper bits set
        for (int k = int'(alu_pkg::SLL); k <= int'(alu_pkg::ROTR); k++) begin
            run_single(alu_pkg::alu_op_e'(k), 32'hffff_ffe0, 32'h8000_0001, 3'd0);
            run_single(alu_pkg::alu_op_e'(k), 32'd31, 32'h8000_0001, 3'd0);
            run_single(alu_pkg::alu_op_e'(k), 32'd31, 32'h7fff_fffe, 3'd0);
        end

        run_single(alu_pkg::CLO, 32'd0, 32'd0, 3'd0);
        run_single(alu_pkg::CLO, 32'hffff_ffff, 32'd0, 3'd0);
        run_single(alu_pkg::CLZ, 32'd0, 32'd0, 3'd0);
        run_single(alu_pkg::CLZ, 32'hffff_ffff, 32'd0, 3'd0);

        // moves, each read one cycle after its write
        ra = $random(seed);
        rb = $random(seed);
        run_single(alu_pkg::MTHI, ra, 32'd0, 3'd0);
        run_single(alu_pkg::MFHI, 32'd0, 32'd0, 3'd0);
        run_single(alu_pkg::MFLO, 32'd0, 32'd0, 3'd0);
        run_single(alu_pkg::MTLO, rb, 32'd0, 3'd0);
        run_single(alu_pkg::MFLO, 32'd0, 32'd0, 3'd0);
        run_single(alu_pkg::MFHI, 32'd0, 32'd0, 3'd0);
        for (int s = 0; s < 8; s++) begin
            ra = $random(seed);
            run_single(alu_pkg::MTC0, ra, 32'd0, 3'(s));
            run_single(alu_pkg::MFC0, 32'd0, 32'd0, 3'(s));
        end

        // multiplies
        repeat (3) begin
            ra = $random(seed);
            rb = $random(seed);
            run_long(alu_pkg::MULT, ra, rb);
            run_long(alu_pkg::MULTU, ra, rb);
        end
        run_long(alu_pkg::MULT, 32'h8000_0000, 32'h8000_0000);
        run_long(alu_pkg::MULT, 32'h8000_0000, 32'h7fff_ffff);
        run_long(alu_pkg::MULT, 32'hffff_ffff, 32'h7fff_ffff);
        run_long(alu_pkg::MULTU, 32'hffff_ffff, 32'hffff_ffff);

        // accumulates from a preloaded HI/LO
        for (int k = int'(alu_pkg::MADD); k <= int'(alu_pkg::MSUBU); k++) begin
            ra = $random(seed);
            rb = $random(seed);
            run_single(alu_pkg::MTHI, ra, 32'd0, 3'd0);
            run_single(alu_pkg::MTLO, rb, 32'd0, 3'd0);
            ra = $random(seed);
            rb = $random(seed);
            run_long(alu_pkg::alu_op_e'(k), ra, rb);
        end

        // divides
        repeat (3) begin
            ra = $random(seed);
            rb = $random(seed);
            run_long(alu_pkg::DIV, ra, rb);
            run_long(alu_pkg::DIVU, ra, rb);
        end
        run_long(alu_pkg::DIV, 32'hffff_fff9, 32'd2);
        run_long(alu_pkg::DIV, 32'd7, 32'hffff_fffe);
        run_long(alu_pkg::DIV, 32'hffff_fff9, 32'hffff_fffe);
        run_long(alu_pkg::DIV, 32'h8000_0000, 32'd3);
        run_long(alu_pkg::DIVU, 32'hffff_fff9, 32'd2);
        run_long(alu_pkg::DIV, 32'hffff_0000, 32'd0);
        run_long(alu_pkg::DIV, 32'd12345, 32'd0);
        run_long(alu_pkg::DIVU, $random(seed), 32'd0);

        // divide straight into multiply, then a NOP for the last HI/LO
        ra = $random(seed);
        rb = $random(seed);
        run_long(alu_pkg::DIV, ra, rb);
        run_long(alu_pkg::MULTU, rb, ra);
        run_single(alu_pkg::NOP, 32'd0, 32'd0, 3'd0);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
